// File: matmul_top.f
hw/matmul_pkg.sv
hw/apb_cfg_pkg.sv
hw/apb_cfg_regs.sv
hw/ram_bank.sv
hw/systolic_array.sv
hw/matmul_sequencer.sv
hw/matmul_top.sv
sim/tb_matmul_top.sv

// File: Makefile
# Verilator build and run for the matrix-multiply accelerator

VERILATOR ?= verilator
TOP       ?= tb_matmul_top
FILELIST  ?= matmul_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_matmul_top.sv
module tb_matmul_top;
  import matmul_pkg::*;
  import apb_cfg_pkg::*;

  typedef row_t [TILE-1:0] mat_t;  // m[i][j], row i at index i

  localparam int          APB_TIMEOUT = 20;
  localparam int          DONE_POLLS  = 100;
  localparam logic [31:0] ADDR_MASK   = 32'((1 << AWIDTH) - 1);

  logic        clk;
  logic        PRESETn;
  logic [7:0]  PADDR;
  logic        PWRITE;
  logic        PSEL;
  logic        PENABLE;
  logic [31:0] PWDATA;
  logic [31:0] PRDATA;
  logic        PREADY;
  logic [7:0]  bram_select;
  bank_addr_t  bram_addr_ext;
  row_t        bram_wdata_ext;
  logic        bram_we_ext;
  row_t        bram_rdata_ext;

  int          seed = 8698;
  int          errors;
  int          checks;
  int          test_errors;
  string       name_q[$];  // Pending compares
  logic [31:0] want_q[$];
  logic [31:0] got_q[$];
  mat_t        mat_a, mat_b;
  logic [31:0] rd;
  row_t        row, guard_lo, guard_hi;
  row_t        saved [3];
  logic [7:0]  cfg_regs [3];
  logic [31:0] cfg_vals [3];

  matmul_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Compare process
  always @(posedge clk) begin : compare
    string       n;
    logic [31:0] w, g;
    while (name_q.size() > 0) begin
      n = name_q.pop_front();
      w = want_q.pop_front();
      g = got_q.pop_front();
      checks++;
      if (g !== w) begin
        $display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h", $time, n, w, g);
        errors++;
      end
    end
  end

  task automatic expect_eq(input string name, input logic [31:0] want, input logic [31:0] got);
    name_q.push_back(name);
    want_q.push_back(want);
    got_q.push_back(got);
  endtask

  ////////////////////
  // Bus tasks
  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (PREADY !== 1'b1 && n < APB_TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (PREADY !== 1'b1) begin
      $display("APB %s at 0x%02h got no PREADY within %0d cycles", what, PADDR, APB_TIMEOUT);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    PENABLE = 1'b0;
    @(posedge clk);
    #1;
    PENABLE = 1'b1;  // Access phase
    wait_ready("write");
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PADDR   = addr;
    PENABLE = 1'b0;
    @(posedge clk);
    #1;
    PENABLE = 1'b1;
    wait_ready("read");
    data    = PRDATA;  // Valid while PREADY is high
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic bank_write(input logic [7:0] sel, input bank_addr_t addr, input row_t data);
    @(posedge clk);
    #1;
    bram_select    = sel;
    bram_addr_ext  = addr;
    bram_wdata_ext = data;
    bram_we_ext    = 1'b1;
    @(posedge clk);
    #1;
    bram_we_ext    = 1'b0;
  endtask

  task automatic bank_read(input logic [7:0] sel, input bank_addr_t addr, output row_t data);
    @(posedge clk);
    #1;
    bram_select   = sel;
    bram_addr_ext = addr;
    bram_we_ext   = 1'b0;
    @(posedge clk);
    #1;
    data = bram_rdata_ext;  // One read cycle
  endtask

  ////////////////////
  // Reference model
  function automatic mat_t ref_matmul(input mat_t a, input mat_t b);
    mat_t  c;
    int    sum;
    elem_t ea, eb;
    c = '0;
    for (int i = 0; i < TILE; i++) begin
      for (int j = 0; j < TILE; j++) begin
        sum = 0;
        for (int k = 0; k < TILE; k++) begin
          ea  = a[i][k];
          eb  = b[k][j];
          sum += int'(ea) * int'(eb);  // Exact signed sum
        end
        c[i][j] = sum[DWIDTH-1:0];
      end
    end
    return c;
  endfunction

  function automatic mat_t random_matrix();
    mat_t m;
    int   r;
    for (int i = 0; i < TILE; i++) begin
      for (int j = 0; j < TILE; j++) begin
        r       = $random(seed);
        m[i][j] = r[DWIDTH-1:0];
      end
    end
    return m;
  endfunction

  // A goes in by columns, B by rows
  task automatic load_operands(input bank_addr_t base_a, input bank_addr_t base_b,
                               input mat_t a, input mat_t b);
    row_t col;
    for (int k = 0; k < TILE; k++) begin
      for (int i = 0; i < TILE; i++) col[i] = a[i][k];
      bank_write(8'd0, base_a + AWIDTH'(k), col);
      bank_write(8'd1, base_b + AWIDTH'(k), b[k]);
    end
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          n;
    n  = 0;
    st = '0;
    while (!st[31] && n < DONE_POLLS) begin
      apb_read(REG_CTRL_ADDR, st);
      n++;
    end
    if (!st[31]) begin
      $display("done did not rise within %0d status polls", DONE_POLLS);
      errors++;
    end else begin
      expect_eq("PRDATA ctrl after done", 32'h8000_0000, st);
    end
  endtask

  task automatic run_and_check(input bank_addr_t base_c, input mat_t a, input mat_t b);
    logic [31:0] st;
    row_t        got;
    mat_t        want;
    want = ref_matmul(a, b);
    apb_write(REG_CTRL_ADDR, 32'h0000_0001);
    apb_read(REG_CTRL_ADDR, st);
    expect_eq("PRDATA ctrl busy", 32'h0000_0001, st);
    wait_done();
    for (int i = 0; i < TILE; i++) begin
      bank_read(8'd2, base_c + AWIDTH'(i), got);
      expect_eq($sformatf("bram_rdata_ext C row %0d", i), want[i], got);
    end
  endtask

  task automatic end_test(input int num, input string title);
    int n;
    n = 0;
    while (name_q.size() > 0 && n < 10) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (name_q.size() > 0) begin
      $display("compare queue still holds %0d entries", name_q.size());
      errors++;
    end
    $display("Test %0d %s: %s", num, title, (errors == test_errors) ? "ok" : "FAILED");
    test_errors = errors;
  endtask

  ////////////////////
  // Stimulus
  initial begin
    PRESETn = 1'b0;
    PADDR = '0;
    PWRITE = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWDATA = '0;
    bram_select = '0;
    bram_addr_ext = '0;
    bram_wdata_ext = '0;
    bram_we_ext = 1'b0;
    errors = 0;
    checks = 0;
    test_errors = 0;
    cfg_regs = '{REG_MAT_A_ADDR, REG_MAT_B_ADDR, REG_MAT_C_ADDR};
    cfg_vals = '{32'hFFFF_F3A5, 32'h0000_0C21, 32'h1234_5678};
    repeat (10) @(posedge clk);
    #1 PRESETn = 1'b1;

    for (int r = 0; r < 3; r++) begin
      apb_read(cfg_regs[r], rd);
      expect_eq($sformatf("PRDATA reg 0x%02h after reset", cfg_regs[r]), 32'h0, rd);
    end
    apb_read(REG_CTRL_ADDR, rd);
    expect_eq("PRDATA ctrl after reset", 32'h0, rd);
    for (int r = 0; r < 3; r++) apb_write(cfg_regs[r], cfg_vals[r]);
    for (int r = 0; r < 3; r++) begin
      apb_read(cfg_regs[r], rd);
      expect_eq($sformatf("PRDATA reg 0x%02h", cfg_regs[r]), cfg_vals[r] & ADDR_MASK, rd);
    end
    end_test(1, "reset values and readback");

    apb_write(8'h40, 32'hDEAD_BEEF);  // Undefined offset
    apb_read(8'h00, rd);
    expect_eq("PRDATA sink at 0x00", 32'hDEAD_BEEF, rd);
    apb_read(8'h7C, rd);
    expect_eq("PRDATA sink at 0x7C", 32'hDEAD_BEEF, rd);
    for (int r = 0; r < 3; r++) begin
      apb_read(cfg_regs[r], rd);
      expect_eq($sformatf("PRDATA reg 0x%02h", cfg_regs[r]), cfg_vals[r] & ADDR_MASK, rd);
    end
    apb_read(REG_CTRL_ADDR, rd);
    expect_eq("PRDATA ctrl", 32'h0, rd);
    end_test(2, "sink register");

    for (int s = 0; s < 3; s++) begin
      saved[s] = $random(seed);
      bank_write(8'(s), 10'h100, saved[s]);
    end
    for (int s = 0; s < 3; s++) begin
      bank_read(8'(s), 10'h100, row);
      expect_eq($sformatf("bram_rdata_ext bank %0d", s), saved[s], row);
    end
    bank_write(8'd3, 10'h100, ~saved[0]);
    bank_read(8'd3, 10'h100, row);
    expect_eq("bram_rdata_ext select 3", 32'h0, row);
    for (int s = 0; s < 3; s++) begin
      bank_read(8'(s), 10'h100, row);
      expect_eq($sformatf("bram_rdata_ext bank %0d kept", s), saved[s], row);
    end
    end_test(3, "external bank access");

    mat_a = random_matrix();
    mat_b = random_matrix();
    for (int r = 0; r < 3; r++) apb_write(cfg_regs[r], 32'h0);
    load_operands(10'h000, 10'h000, mat_a, mat_b);
    run_and_check(10'h000, mat_a, mat_b);
    end_test(4, "matrix multiply at base 0");

    guard_lo = $random(seed);
    guard_hi = $random(seed);
    bank_write(8'd2, 10'h154, guard_lo);  // Just outside the C block
    bank_write(8'd2, 10'h159, guard_hi);
    apb_write(REG_CTRL_ADDR, 32'h8000_0000);
    mat_a = random_matrix();
    mat_b = random_matrix();
    load_operands(10'h040, 10'h2F0, mat_a, mat_b);
    apb_write(REG_MAT_A_ADDR, 32'h040);
    apb_write(REG_MAT_B_ADDR, 32'h2F0);
    apb_write(REG_MAT_C_ADDR, 32'h155);
    run_and_check(10'h155, mat_a, mat_b);
    bank_read(8'd2, 10'h154, row);
    expect_eq("bram_rdata_ext C guard below", guard_lo, row);
    bank_read(8'd2, 10'h159, row);
    expect_eq("bram_rdata_ext C guard above", guard_hi, row);
    end_test(5, "matrix multiply at other bases");

    apb_write(REG_CTRL_ADDR, 32'h8000_0000);
    apb_read(REG_CTRL_ADDR, rd);
    expect_eq("PRDATA ctrl after clear_done", 32'h0, rd);
    mat_b = random_matrix();
    load_operands(10'h040, 10'h2F0, mat_a, mat_b);
    run_and_check(10'h155, mat_a, mat_b);
    end_test(6, "clearing done");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: hw/matmul_top.sv
module matmul_top (
  input  logic                                   clk,
  input  logic                                   PRESETn,
  input  logic [apb_cfg_pkg::REG_ADDR_WIDTH-1:0] PADDR,
  input  logic                                   PWRITE,
  input  logic                                   PSEL,
  input  logic                                   PENABLE,
  input  logic [apb_cfg_pkg::REG_DATA_WIDTH-1:0] PWDATA,
  output logic [apb_cfg_pkg::REG_DATA_WIDTH-1:0] PRDATA,
  output logic                                   PREADY,
  input  logic [7:0]                             bram_select,
  input  matmul_pkg::bank_addr_t                 bram_addr_ext,
  input  matmul_pkg::row_t                       bram_wdata_ext,
  input  logic                                   bram_we_ext,
  output matmul_pkg::row_t                       bram_rdata_ext
);
  import apb_cfg_pkg::*;
  import matmul_pkg::*;

  mm_cfg_t         cfg;
  logic            start;
  logic            clear_done;
  logic            busy;
  logic            done;
  logic            clear;
  logic            valid;
  row_t            a_col;
  row_t            b_row;
  row_t [TILE-1:0] result;
  ram_port_t       seq_a, seq_b, seq_c;  // Port 0 belongs to the sequencer
  ram_port_t       ext_a, ext_b, ext_c;  // Port 1 belongs to the host
  row_t            a_rdata, b_rdata;
  row_t            ext_rdata_a, ext_rdata_b, ext_rdata_c;

  ////////////////////
  // External bank select
  always_comb begin
    ext_a = '{addr: bram_addr_ext, wdata: bram_wdata_ext, we: 1'b0};
    ext_b = ext_a;
    ext_c = ext_a;
    case (bram_select)
      8'd0: begin
        ext_a.we       = bram_we_ext;
        bram_rdata_ext = ext_rdata_a;
      end
      8'd1: begin
        ext_b.we       = bram_we_ext;
        bram_rdata_ext = ext_rdata_b;
      end
      8'd2: begin
        ext_c.we       = bram_we_ext;
        bram_rdata_ext = ext_rdata_c;
      end
      default: bram_rdata_ext = '0;  // Nothing selected so nothing written
    endcase
  end

  ////////////////////
  // Banks
  ram_bank bank_a (.clk(clk), .port_a(seq_a), .port_b(ext_a),
                   .rdata_a(a_rdata), .rdata_b(ext_rdata_a));
  ram_bank bank_b (.clk(clk), .port_a(seq_b), .port_b(ext_b),
                   .rdata_a(b_rdata), .rdata_b(ext_rdata_b));
  ram_bank bank_c (.clk(clk), .port_a(seq_c), .port_b(ext_c),
                   .rdata_a(), .rdata_b(ext_rdata_c));  // C is write-only here

  ////////////////////
  // Control and compute
  apb_cfg_regs u_regs (
    .clk(clk), .PRESETn(PRESETn),
    .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
    .PWDATA(PWDATA), .busy(busy), .done(done),
    .PRDATA(PRDATA), .PREADY(PREADY), .cfg(cfg),
    .start(start), .clear_done(clear_done)
  );

  matmul_sequencer u_seq (
    .clk(clk), .PRESETn(PRESETn),
    .start(start), .clear_done(clear_done), .cfg(cfg),
    .a_rdata(a_rdata), .b_rdata(b_rdata), .result(result),
    .a_port(seq_a), .b_port(seq_b), .c_port(seq_c),
    .clear(clear), .valid(valid), .a_col(a_col), .b_row(b_row),
    .busy(busy), .done(done)
  );

  systolic_array u_array (
    .clk(clk), .PRESETn(PRESETn),
    .clear(clear), .valid(valid),
    .a_col(a_col), .b_row(b_row),
    .result(result)
  );

endmodule

// File: hw/matmul_sequencer.sv
module matmul_sequencer (
  input  logic                                    clk,
  input  logic                                    PRESETn,
  input  logic                                    start,
  input  logic                                    clear_done,
  input  apb_cfg_pkg::mm_cfg_t                    cfg,
  input  matmul_pkg::row_t                        a_rdata,
  input  matmul_pkg::row_t                        b_rdata,
  input  matmul_pkg::row_t [matmul_pkg::TILE-1:0] result,
  output matmul_pkg::ram_port_t                   a_port,
  output matmul_pkg::ram_port_t                   b_port,
  output matmul_pkg::ram_port_t                   c_port,
  output logic                                    clear,
  output logic                                    valid,
  output matmul_pkg::row_t                        a_col,
  output matmul_pkg::row_t                        b_row,
  output logic                                    busy,
  output logic                                    done
);
  import matmul_pkg::*;

  logic [2:0]         state;
  logic [STEP_W-1:0]  step;       // Operand read or result row index
  logic [FLUSH_W-1:0] flush_cnt;

  ////////////////////
  // Control FSM
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state     <= S_IDLE;
      step      <= '0;
      flush_cnt <= '0;
      valid     <= 1'b0;
    end else begin
      valid <= (state == S_FEED);  // Rows come back one cycle after the read
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_CLEAR;
          end
        end
        S_CLEAR: begin
          step  <= '0;
          state <= S_FEED;
        end
        S_FEED: begin
          step <= step + STEP_W'(1);
          if (step == STEP_LAST) begin
            step      <= '0;
            flush_cnt <= '0;
            state     <= S_FLUSH;
          end
        end
        S_FLUSH: begin
          flush_cnt <= flush_cnt + FLUSH_W'(1);
          if (flush_cnt == FLUSH_LAST) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          step <= step + STEP_W'(1);
          if (step == STEP_LAST) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          if (clear_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign clear = (state == S_CLEAR);
  assign busy  = (state != S_IDLE) && (state != S_DONE);
  assign done  = (state == S_DONE);

  // Column k of A and row k of B sit at base + k
  assign a_col = a_rdata;
  assign b_row = b_rdata;

  ////////////////////
  // Bank ports
  always_comb begin
    a_port = '{addr: cfg.addr_a + AWIDTH'(step), wdata: '0, we: 1'b0};
    b_port = '{addr: cfg.addr_b + AWIDTH'(step), wdata: '0, we: 1'b0};
    c_port = '{addr:  cfg.addr_c + AWIDTH'(step),
               wdata: result[step],
               we:    (state == S_WRITE)};
  end

endmodule

// File: hw/systolic_array.sv
module systolic_array (
  input  logic                                    clk,
  input  logic                                    PRESETn,
  input  logic                                    clear,
  input  logic                                    valid,
  input  matmul_pkg::row_t                        a_col,
  input  matmul_pkg::row_t                        b_row,
  output matmul_pkg::row_t [matmul_pkg::TILE-1:0] result
);
  import matmul_pkg::*;

  row_t  a_in;
  row_t  b_in;
  elem_t a_bus [TILE][TILE];  // A entering cell [i][j]
  elem_t b_bus [TILE][TILE];  // B entering cell [i][j]

  // Idle cycles feed zeros so sums stay put
  assign a_in = valid ? a_col : '0;
  assign b_in = valid ? b_row : '0;

  ////////////////////
  // Input skew
  for (genvar l = 0; l < TILE; l++) begin : g_skew
    if (l == 0) begin : g_direct
      assign a_bus[0][0] = a_in[0];
      assign b_bus[0][0] = b_in[0];
    end else begin : g_delay
      elem_t a_dly [l];  // Lane l waits l cycles
      elem_t b_dly [l];
      always_ff @(posedge clk) begin
        if (!PRESETn) begin
          a_dly <= '{default: '0};
          b_dly <= '{default: '0};
        end else begin
          a_dly[0] <= a_in[l];
          b_dly[0] <= b_in[l];
          for (int d = 1; d < l; d++) begin
            a_dly[d] <= a_dly[d-1];
            b_dly[d] <= b_dly[d-1];
          end
        end
      end
      assign a_bus[l][0] = a_dly[l-1];
      assign b_bus[0][l] = b_dly[l-1];
    end
  end

  ////////////////////
  // MAC grid
  for (genvar i = 0; i < TILE; i++) begin : g_row
    for (genvar j = 0; j < TILE; j++) begin : g_col
      logic signed [ACC_WIDTH-1:0] acc;

      always_ff @(posedge clk) begin
        if (!PRESETn || clear) begin
          acc <= '0;
        end else begin
          acc <= acc + ACC_WIDTH'(a_bus[i][j]) * ACC_WIDTH'(b_bus[i][j]);
        end
      end
      assign result[i][j] = acc[DWIDTH-1:0];  // Low bits only

      // Forward registers stop at the last column and row
      if (j < TILE - 1) begin : g_pass_a
        elem_t a_q;
        always_ff @(posedge clk) begin
          a_q <= PRESETn ? a_bus[i][j] : '0;
        end
        assign a_bus[i][j+1] = a_q;
      end
      if (i < TILE - 1) begin : g_pass_b
        elem_t b_q;
        always_ff @(posedge clk) begin
          b_q <= PRESETn ? b_bus[i][j] : '0;
        end
        assign b_bus[i+1][j] = b_q;
      end
    end
  end

endmodule

// File: hw/ram_bank.sv
module ram_bank (
  input  logic                  clk,
  input  matmul_pkg::ram_port_t port_a,
  input  matmul_pkg::ram_port_t port_b,
  output matmul_pkg::row_t      rdata_a,
  output matmul_pkg::row_t      rdata_b
);
  import matmul_pkg::*;

  row_t mem [2**AWIDTH];  // One matrix row per word

  // Both ports write at their own address
  always_ff @(posedge clk) begin
    if (port_a.we) begin
      mem[port_a.addr] <= port_a.wdata;
    end
    if (port_b.we) begin
      mem[port_b.addr] <= port_b.wdata;  // Port B wins a same-address clash
    end
    rdata_a <= mem[port_a.addr];  // Old data on read-during-write
    rdata_b <= mem[port_b.addr];
  end

endmodule

// File: hw/apb_cfg_regs.sv
module apb_cfg_regs (
  input  logic                                   clk,
  input  logic                                   PRESETn,
  input  logic [apb_cfg_pkg::REG_ADDR_WIDTH-1:0] PADDR,
  input  logic                                   PWRITE,
  input  logic                                   PSEL,
  input  logic                                   PENABLE,
  input  logic [apb_cfg_pkg::REG_DATA_WIDTH-1:0] PWDATA,
  input  logic                                   busy,
  input  logic                                   done,
  output logic [apb_cfg_pkg::REG_DATA_WIDTH-1:0] PRDATA,
  output logic                                   PREADY,
  output apb_cfg_pkg::mm_cfg_t                   cfg,
  output logic                                   start,
  output logic                                   clear_done
);
  import apb_cfg_pkg::*;
  import matmul_pkg::*;

  logic [1:0]                state;
  logic [REG_DATA_WIDTH-1:0] sink;      // Catches undefined addresses
  ctrl_word_u                ctrl_in;   // PWDATA seen as a command
  ctrl_word_u                ctrl_out;  // Status as software reads it

  assign ctrl_in = PWDATA;

  always_comb begin
    ctrl_out         = '0;
    ctrl_out.rd.busy = busy;
    ctrl_out.rd.done = done;
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state      <= APB_IDLE;
      PRDATA     <= '0;
      PREADY     <= 1'b0;
      cfg        <= '0;
      sink       <= '0;
      start      <= 1'b0;
      clear_done <= 1'b0;
    end else begin
      start      <= 1'b0;  // Strobes last one cycle
      clear_done <= 1'b0;
      case (state)
        APB_IDLE: begin
          PRDATA <= '0;
          PREADY <= 1'b0;
          if (PSEL) begin
            state <= PWRITE ? APB_WRITE : APB_READ;
          end
        end

        APB_WRITE: begin
          if (PSEL && PWRITE && PENABLE) begin
            case (PADDR)
              REG_CTRL_ADDR: begin
                start      <= ctrl_in.wr.start;
                clear_done <= ctrl_in.wr.clear_done;
              end
              REG_MAT_A_ADDR: cfg.addr_a <= PWDATA[AWIDTH-1:0];
              REG_MAT_B_ADDR: cfg.addr_b <= PWDATA[AWIDTH-1:0];
              REG_MAT_C_ADDR: cfg.addr_c <= PWDATA[AWIDTH-1:0];
              default:        sink <= PWDATA;
            endcase
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end

        APB_READ: begin
          if (PSEL && !PWRITE && PENABLE) begin
            case (PADDR)
              REG_CTRL_ADDR:  PRDATA <= ctrl_out;
              REG_MAT_A_ADDR: PRDATA <= REG_DATA_WIDTH'(cfg.addr_a);
              REG_MAT_B_ADDR: PRDATA <= REG_DATA_WIDTH'(cfg.addr_b);
              REG_MAT_C_ADDR: PRDATA <= REG_DATA_WIDTH'(cfg.addr_c);
              default:        PRDATA <= sink;
            endcase
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end

        default: state <= APB_IDLE;
      endcase
    end
  end

endmodule

// File: hw/apb_cfg_pkg.sv
package apb_cfg_pkg;

  import matmul_pkg::bank_addr_t;

  localparam int REG_DATA_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 8;

  // Register map
  localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL_ADDR  = 8'h04;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MAT_A_ADDR = 8'h0E;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MAT_B_ADDR = 8'h12;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_MAT_C_ADDR = 8'h16;

  // APB slave states
  localparam logic [1:0] APB_IDLE  = 2'b00;
  localparam logic [1:0] APB_WRITE = 2'b01;
  localparam logic [1:0] APB_READ  = 2'b10;

  typedef struct packed {
    logic        clear_done;  // Bit 31
    logic [29:0] reserved;
    logic        start;       // Bit 0
  } ctrl_wr_t;

  typedef struct packed {
    logic        done;
    logic [29:0] zero;
    logic        busy;
  } ctrl_rd_t;

  typedef union packed {
    ctrl_wr_t wr;
    ctrl_rd_t rd;
  } ctrl_word_u;

  typedef struct packed {
    bank_addr_t addr_a;
    bank_addr_t addr_b;
    bank_addr_t addr_c;
  } mm_cfg_t;

endpackage

// File: hw/matmul_pkg.sv
package matmul_pkg;

  localparam int TILE         = 4;
  localparam int DWIDTH       = 8;
  localparam int AWIDTH       = 10;
  localparam int ACC_WIDTH    = 16;
  localparam int FLUSH_CYCLES = 3 * TILE;  // Skew plus grid drain plus margin

  localparam int STEP_W  = $clog2(TILE);
  localparam int FLUSH_W = $clog2(FLUSH_CYCLES);
  localparam logic [STEP_W-1:0]  STEP_LAST  = STEP_W'(TILE - 1);
  localparam logic [FLUSH_W-1:0] FLUSH_LAST = FLUSH_W'(FLUSH_CYCLES - 1);

  // Sequencer states
  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_CLEAR = 3'd1;
  localparam logic [2:0] S_FEED  = 3'd2;
  localparam logic [2:0] S_FLUSH = 3'd3;
  localparam logic [2:0] S_WRITE = 3'd4;
  localparam logic [2:0] S_DONE  = 3'd5;

  typedef logic signed [DWIDTH-1:0] elem_t;
  typedef logic [AWIDTH-1:0]        bank_addr_t;
  typedef elem_t [TILE-1:0]         row_t;  // Element j sits at bits j*DWIDTH

  typedef struct packed {
    bank_addr_t addr;
    row_t       wdata;
    logic       we;
  } ram_port_t;

endpackage
